// ==== axi4_pkg.sv ====
////////////////////
// AXI4 bus types
////////////////////

package axi4_pkg;

	// bus widths
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;	// one strobe per byte lane
	localparam int AXI_ID_W   = 8;

	// byte address
	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

	// one data beat, always full width
	typedef logic [AXI_DATA_W-1:0] axi_data_t;

	typedef logic [AXI_STRB_W-1:0] axi_strb_t;	// byte enables
	typedef logic [AXI_ID_W-1:0]   axi_id_t;	// transaction id
	typedef logic [1:0]            axi_resp_t;	// BRESP / RRESP

	// response codes
	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_EXOKAY = 2'b01;	// exclusive ok, never requested here
	localparam axi_resp_t RESP_SLVERR = 2'b10;	// slave error
	localparam axi_resp_t RESP_DECERR = 2'b11;	// no slave at address

endpackage

// ==== biu_pkg.sv ====
////////////////////
// BIU client types
////////////////////

package biu_pkg;

	// client id, must fit in AXI_ID_W
	localparam int CID_W = 4;

	// client side queues
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);

	// incoming B/R beat buffers inside the bus unit
	localparam int INQ_DEPTH = 4;
	localparam int INQ_AW    = $clog2(INQ_DEPTH);

	typedef logic [CID_W-1:0]  cid_t;
	typedef logic [QUEUE_AW:0] qptr_t;	// index plus wrap bit
	typedef logic [INQ_AW:0]   inq_ptr_t;	// index plus wrap bit

	// single-beat write request
	typedef struct packed {
		cid_t                cid;
		axi4_pkg::axi_addr_t addr;
		axi4_pkg::axi_data_t data;
		axi4_pkg::axi_strb_t strb;
	} biu_wr_req_t;

	typedef struct packed {
		cid_t                cid;
		axi4_pkg::axi_addr_t addr;
	} biu_rd_req_t;

	// write completion, tagged with requester
	typedef struct packed {
		cid_t                cid;
		axi4_pkg::axi_resp_t resp;
	} biu_wr_rsp_t;

	typedef struct packed {
		cid_t                cid;
		axi4_pkg::axi_data_t data;
		axi4_pkg::axi_resp_t resp;
	} biu_rd_rsp_t;

endpackage

// ==== biu_req_fifo.sv ====
////////////////////
// request queue
////////////////////

`timescale 1ns/1ps

module biu_req_fifo #(
	parameter type entry_t = logic
) (
	input  logic   M_AXI4_ACLK,
	input  logic   M_AXI4_ARESETn,
	// client side
	input  logic   push,
	input  entry_t din,
	output logic   full,
	// bus unit side
	input  logic   pop,
	output logic   valid,
	output entry_t dout
);
	import biu_pkg::*;

	entry_t mem [QUEUE_DEPTH];	// entry storage
	qptr_t  wp;			// write pointer
	qptr_t  rp;			// read pointer
	qptr_t  wp_nxt;
	qptr_t  rp_nxt;
	logic   wr_en;
	logic   rd_en;

	// same index, different wrap bit means full
	assign full  = (wp[QUEUE_AW-1:0] == rp[QUEUE_AW-1:0]) && (wp[QUEUE_AW] != rp[QUEUE_AW]);
	assign valid = (wp != rp);
	assign dout  = mem[rp[QUEUE_AW-1:0]];	// head shown ahead of pop

	assign wr_en = push && !full;
	assign rd_en = pop && valid;	// bus unit takes dout on this edge

	assign wp_nxt = wr_en ? wp + qptr_t'(1) : wp;
	assign rp_nxt = rd_en ? rp + qptr_t'(1) : rp;

	always_ff @(posedge M_AXI4_ACLK or negedge M_AXI4_ARESETn)
	begin
		if (!M_AXI4_ARESETn)
		begin
			wp <= '0;
			rp <= '0;
		end
		else
		begin
			wp <= wp_nxt;
			rp <= rp_nxt;
		end
	end

	// storage write
	always_ff @(posedge M_AXI4_ACLK)
	begin
		if (wr_en)
			mem[wp[QUEUE_AW-1:0]] <= din;
	end

endmodule

// ==== biu_rsp_fifo.sv ====
////////////////////
// response queue
////////////////////

`timescale 1ns/1ps

module biu_rsp_fifo #(
	parameter type entry_t = logic
) (
	input  logic   M_AXI4_ACLK,
	input  logic   M_AXI4_ARESETn,
	// bus unit side, push held until ready
	input  logic   push,
	input  entry_t din,
	output logic   ready,
	// client side
	input  logic   pop,
	output logic   empty,
	output entry_t dout
);
	import biu_pkg::*;

	entry_t mem [QUEUE_DEPTH];
	qptr_t  wp;
	qptr_t  rp;
	logic   full;
	logic   wr_en;
	logic   rd_en;

	assign full  = (wp[QUEUE_AW-1:0] == rp[QUEUE_AW-1:0]) && (wp[QUEUE_AW] != rp[QUEUE_AW]);
	assign empty = (wp == rp);
	assign ready = !full;			// bus unit holds its entry while low
	assign dout  = mem[rp[QUEUE_AW-1:0]];	// head visible while not empty

	assign wr_en = push && ready;
	assign rd_en = pop && !empty;	// stray pop on empty ignored

	always_ff @(posedge M_AXI4_ACLK or negedge M_AXI4_ARESETn)
	begin
		if (!M_AXI4_ARESETn)
		begin
			wp <= '0;
			rp <= '0;
		end
		else
		begin
			if (wr_en)
				wp <= wp + qptr_t'(1);
			if (rd_en)
				rp <= rp + qptr_t'(1);
		end
	end

	always_ff @(posedge M_AXI4_ACLK)
	begin
		if (wr_en)
			mem[wp[QUEUE_AW-1:0]] <= din;
	end

endmodule

// ==== axi4_master_biu.sv ====
////////////////////
// AXI4 master BIU
////////////////////

`timescale 1ns/1ps

// single-beat, full-width, FIXED burst transactions only
module axi4_master_biu (
	input  logic                  M_AXI4_ACLK,
	input  logic                  M_AXI4_ARESETn,
	// write address channel
	output axi4_pkg::axi_id_t     M_AXI4_AWID,
	output axi4_pkg::axi_addr_t   M_AXI4_AWADDR,
	output logic                  M_AXI4_AWVALID,
	input  logic                  M_AXI4_AWREADY,
	// write data channel
	output axi4_pkg::axi_data_t   M_AXI4_WDATA,
	output axi4_pkg::axi_strb_t   M_AXI4_WSTRB,
	output logic                  M_AXI4_WVALID,
	input  logic                  M_AXI4_WREADY,
	// write response channel
	input  axi4_pkg::axi_id_t     M_AXI4_BID,
	input  axi4_pkg::axi_resp_t   M_AXI4_BRESP,
	input  logic                  M_AXI4_BVALID,
	output logic                  M_AXI4_BREADY,
	// read address channel
	output axi4_pkg::axi_id_t     M_AXI4_ARID,
	output axi4_pkg::axi_addr_t   M_AXI4_ARADDR,
	output logic                  M_AXI4_ARVALID,
	input  logic                  M_AXI4_ARREADY,
	// read data channel
	input  axi4_pkg::axi_id_t     M_AXI4_RID,
	input  axi4_pkg::axi_data_t   M_AXI4_RDATA,
	input  axi4_pkg::axi_resp_t   M_AXI4_RRESP,
	input  logic                  M_AXI4_RLAST,
	input  logic                  M_AXI4_RVALID,
	output logic                  M_AXI4_RREADY,
	// request queues, valid/pop
	input  biu_pkg::biu_wr_req_t  wr_req,
	input  logic                  wr_req_valid,
	output logic                  wr_req_pop,
	input  biu_pkg::biu_rd_req_t  rd_req,
	input  logic                  rd_req_valid,
	output logic                  rd_req_pop,
	// response queues, ready/push
	output biu_pkg::biu_wr_rsp_t  wr_rsp,
	output logic                  wr_rsp_push,
	input  logic                  wr_rsp_ready,
	output biu_pkg::biu_rd_rsp_t  rd_rsp,
	output logic                  rd_rsp_push,
	input  logic                  rd_rsp_ready
);
	import axi4_pkg::*;
	import biu_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,	// nothing outstanding
		ST_SEND,	// pop high, head sampled at edge
		ST_WAIT		// VALID up, waiting for ready
	} req_state_t;

	// true once the buffer would hold INQ_DEPTH-1 or more beats
	function automatic logic inq_blocked(inq_ptr_t wp_n, inq_ptr_t rp_n);
		inq_ptr_t used;
		used = wp_n - rp_n;
		return (used >= inq_ptr_t'(INQ_DEPTH - 1));
	endfunction

	req_state_t aw_state;
	req_state_t ar_state;
	logic       aw_done;	// AW side accepted or already gone
	logic       w_done;
	logic       ar_done;

	assign aw_done = !M_AXI4_AWVALID || M_AXI4_AWREADY;
	assign w_done  = !M_AXI4_WVALID || M_AXI4_WREADY;
	assign ar_done = !M_AXI4_ARVALID || M_AXI4_ARREADY;

	// write request machine, AW and W raised together
	always_ff @(posedge M_AXI4_ACLK or negedge M_AXI4_ARESETn)
	begin
		if (!M_AXI4_ARESETn)
		begin
			aw_state       <= ST_IDLE;
			M_AXI4_AWVALID <= 1'b0;
			M_AXI4_WVALID  <= 1'b0;
			wr_req_pop     <= 1'b0;
		end
		else
		begin
			case (aw_state)
				ST_IDLE:
				begin
					if (wr_req_valid)
					begin
						wr_req_pop <= 1'b1;
						aw_state   <= ST_SEND;
					end
				end
				ST_SEND:
				begin
					wr_req_pop     <= 1'b0;	// queue advanced this edge
					M_AXI4_AWVALID <= 1'b1;
					M_AXI4_WVALID  <= 1'b1;
					aw_state       <= ST_WAIT;
				end
				ST_WAIT:
				begin
					if (M_AXI4_AWREADY)
						M_AXI4_AWVALID <= 1'b0;	// lowered on its own handshake
					if (M_AXI4_WREADY)
						M_AXI4_WVALID <= 1'b0;
					if (aw_done && w_done)
					begin
						// both beats gone, chain next request
						wr_req_pop <= wr_req_valid;
						aw_state   <= wr_req_valid ? ST_SEND : ST_IDLE;
					end
				end
				default: aw_state <= ST_IDLE;
			endcase
		end
	end

	// AW/W payload, loaded while popping
	always_ff @(posedge M_AXI4_ACLK)
	begin
		if (aw_state == ST_SEND)
		begin
			M_AXI4_AWID   <= axi_id_t'(wr_req.cid);	// zero-extended client id
			M_AXI4_AWADDR <= wr_req.addr;
			M_AXI4_WDATA  <= wr_req.data;
			M_AXI4_WSTRB  <= wr_req.strb;
		end
	end

	// read request machine
	always_ff @(posedge M_AXI4_ACLK or negedge M_AXI4_ARESETn)
	begin
		if (!M_AXI4_ARESETn)
		begin
			ar_state       <= ST_IDLE;
			M_AXI4_ARVALID <= 1'b0;
			rd_req_pop     <= 1'b0;
		end
		else
		begin
			case (ar_state)
				ST_IDLE:
				begin
					if (rd_req_valid)
					begin
						rd_req_pop <= 1'b1;
						ar_state   <= ST_SEND;
					end
				end
				ST_SEND:
				begin
					rd_req_pop     <= 1'b0;
					M_AXI4_ARVALID <= 1'b1;
					ar_state       <= ST_WAIT;
				end
				ST_WAIT:
				begin
					if (ar_done)
					begin
						M_AXI4_ARVALID <= 1'b0;
						rd_req_pop     <= rd_req_valid;
						ar_state       <= rd_req_valid ? ST_SEND : ST_IDLE;
					end
				end
				default: ar_state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge M_AXI4_ACLK)
	begin
		if (ar_state == ST_SEND)
		begin
			M_AXI4_ARID   <= axi_id_t'(rd_req.cid);
			M_AXI4_ARADDR <= rd_req.addr;
		end
	end

	// B beat buffer
	biu_wr_rsp_t bfifo [INQ_DEPTH];
	inq_ptr_t    b_wp;
	inq_ptr_t    b_rp;
	inq_ptr_t    b_wp_nxt;
	inq_ptr_t    b_rp_nxt;
	logic        b_block;	// BREADY held low while set
	logic        b_take;
	logic        b_give;

	assign M_AXI4_BREADY = !b_block;
	assign b_take   = M_AXI4_BVALID && M_AXI4_BREADY;	// real handshake only
	assign b_give   = (b_wp != b_rp) && wr_rsp_ready;	// output slot free or draining
	assign b_wp_nxt = b_take ? b_wp + inq_ptr_t'(1) : b_wp;
	assign b_rp_nxt = b_give ? b_rp + inq_ptr_t'(1) : b_rp;

	always_ff @(posedge M_AXI4_ACLK or negedge M_AXI4_ARESETn)
	begin
		if (!M_AXI4_ARESETn)
		begin
			b_wp        <= '0;
			b_rp        <= '0;
			b_block     <= 1'b0;
			wr_rsp_push <= 1'b0;
		end
		else
		begin
			b_wp    <= b_wp_nxt;
			b_rp    <= b_rp_nxt;
			b_block <= inq_blocked(b_wp_nxt, b_rp_nxt);	// stays set until drained
			if (b_give)
				wr_rsp_push <= 1'b1;
			else if (wr_rsp_ready)
				wr_rsp_push <= 1'b0;	// last entry taken, nothing new
		end
	end

	always_ff @(posedge M_AXI4_ACLK)
	begin
		if (b_take)
			bfifo[b_wp[INQ_AW-1:0]] <= '{cid: M_AXI4_BID[CID_W-1:0], resp: M_AXI4_BRESP};
		if (b_give)
			wr_rsp <= bfifo[b_rp[INQ_AW-1:0]];	// held while queue not ready
	end

	// R beat buffer
	biu_rd_rsp_t rfifo [INQ_DEPTH];
	inq_ptr_t    r_wp;
	inq_ptr_t    r_rp;
	inq_ptr_t    r_wp_nxt;
	inq_ptr_t    r_rp_nxt;
	logic        r_block;
	logic        r_take;
	logic        r_give;
	axi_resp_t   r_resp;

	assign M_AXI4_RREADY = !r_block;
	assign r_take   = M_AXI4_RVALID && M_AXI4_RREADY;
	assign r_give   = (r_wp != r_rp) && rd_rsp_ready;
	assign r_wp_nxt = r_take ? r_wp + inq_ptr_t'(1) : r_wp;
	assign r_rp_nxt = r_give ? r_rp + inq_ptr_t'(1) : r_rp;
	// single-beat reads, a beat without RLAST is a slave fault
	assign r_resp   = M_AXI4_RLAST ? M_AXI4_RRESP : RESP_SLVERR;

	always_ff @(posedge M_AXI4_ACLK or negedge M_AXI4_ARESETn)
	begin
		if (!M_AXI4_ARESETn)
		begin
			r_wp        <= '0;
			r_rp        <= '0;
			r_block     <= 1'b0;
			rd_rsp_push <= 1'b0;
		end
		else
		begin
			r_wp    <= r_wp_nxt;
			r_rp    <= r_rp_nxt;
			r_block <= inq_blocked(r_wp_nxt, r_rp_nxt);
			if (r_give)
				rd_rsp_push <= 1'b1;
			else if (rd_rsp_ready)
				rd_rsp_push <= 1'b0;
		end
	end

	always_ff @(posedge M_AXI4_ACLK)
	begin
		if (r_take)
			rfifo[r_wp[INQ_AW-1:0]] <= '{cid: M_AXI4_RID[CID_W-1:0],
				data: M_AXI4_RDATA, resp: r_resp};
		if (r_give)
			rd_rsp <= rfifo[r_rp[INQ_AW-1:0]];
	end

endmodule

// ==== mem_port_top.sv ====
////////////////////
// memory port top
////////////////////

`timescale 1ns/1ps

module mem_port_top (
	input  logic                  M_AXI4_ACLK,
	input  logic                  M_AXI4_ARESETn,
	// AXI4 master
	output axi4_pkg::axi_id_t     M_AXI4_AWID,
	output axi4_pkg::axi_addr_t   M_AXI4_AWADDR,
	output logic                  M_AXI4_AWVALID,
	input  logic                  M_AXI4_AWREADY,
	output axi4_pkg::axi_data_t   M_AXI4_WDATA,
	output axi4_pkg::axi_strb_t   M_AXI4_WSTRB,
	output logic                  M_AXI4_WVALID,
	input  logic                  M_AXI4_WREADY,
	input  axi4_pkg::axi_id_t     M_AXI4_BID,
	input  axi4_pkg::axi_resp_t   M_AXI4_BRESP,
	input  logic                  M_AXI4_BVALID,
	output logic                  M_AXI4_BREADY,
	output axi4_pkg::axi_id_t     M_AXI4_ARID,
	output axi4_pkg::axi_addr_t   M_AXI4_ARADDR,
	output logic                  M_AXI4_ARVALID,
	input  logic                  M_AXI4_ARREADY,
	input  axi4_pkg::axi_id_t     M_AXI4_RID,
	input  axi4_pkg::axi_data_t   M_AXI4_RDATA,
	input  axi4_pkg::axi_resp_t   M_AXI4_RRESP,
	input  logic                  M_AXI4_RLAST,
	input  logic                  M_AXI4_RVALID,
	output logic                  M_AXI4_RREADY,
	// client requests, push/full
	input  logic                  wr_req_push,
	input  biu_pkg::biu_wr_req_t  wr_req,
	output logic                  wr_req_full,
	input  logic                  rd_req_push,
	input  biu_pkg::biu_rd_req_t  rd_req,
	output logic                  rd_req_full,
	// client responses, pop/empty
	input  logic                  wr_rsp_pop,
	output biu_pkg::biu_wr_rsp_t  wr_rsp,
	output logic                  wr_rsp_empty,
	input  logic                  rd_rsp_pop,
	output biu_pkg::biu_rd_rsp_t  rd_rsp,
	output logic                  rd_rsp_empty
);
	import biu_pkg::*;

	biu_wr_req_t wr_head;		// write queue head
	logic        wr_head_valid;
	logic        wr_head_pop;
	biu_rd_req_t rd_head;
	logic        rd_head_valid;
	logic        rd_head_pop;
	biu_wr_rsp_t biu_wr_rsp;	// bus unit to response queue
	logic        biu_wr_push;
	logic        wr_rsp_ready;
	biu_rd_rsp_t biu_rd_rsp;
	logic        biu_rd_push;
	logic        rd_rsp_ready;

	biu_req_fifo #(.entry_t(biu_wr_req_t)) wr_req_q (
		.M_AXI4_ACLK, .M_AXI4_ARESETn,
		.push(wr_req_push), .din(wr_req), .full(wr_req_full),
		.pop(wr_head_pop), .valid(wr_head_valid), .dout(wr_head)
	);

	biu_req_fifo #(.entry_t(biu_rd_req_t)) rd_req_q (
		.M_AXI4_ACLK, .M_AXI4_ARESETn,
		.push(rd_req_push), .din(rd_req), .full(rd_req_full),
		.pop(rd_head_pop), .valid(rd_head_valid), .dout(rd_head)
	);

	biu_rsp_fifo #(.entry_t(biu_wr_rsp_t)) wr_rsp_q (
		.M_AXI4_ACLK, .M_AXI4_ARESETn,
		.push(biu_wr_push), .din(biu_wr_rsp), .ready(wr_rsp_ready),
		.pop(wr_rsp_pop), .empty(wr_rsp_empty), .dout(wr_rsp)
	);

	biu_rsp_fifo #(.entry_t(biu_rd_rsp_t)) rd_rsp_q (
		.M_AXI4_ACLK, .M_AXI4_ARESETn,
		.push(biu_rd_push), .din(biu_rd_rsp), .ready(rd_rsp_ready),
		.pop(rd_rsp_pop), .empty(rd_rsp_empty), .dout(rd_rsp)
	);

	// AXI ports by name, queue links explicit
	axi4_master_biu biu (
		.*,
		.wr_req(wr_head), .wr_req_valid(wr_head_valid), .wr_req_pop(wr_head_pop),
		.rd_req(rd_head), .rd_req_valid(rd_head_valid), .rd_req_pop(rd_head_pop),
		.wr_rsp(biu_wr_rsp), .wr_rsp_push(biu_wr_push), .wr_rsp_ready(wr_rsp_ready),
		.rd_rsp(biu_rd_rsp), .rd_rsp_push(biu_rd_push), .rd_rsp_ready(rd_rsp_ready)
	);

endmodule

// ==== tb_mem_port_asserts.sv ====
////////////////////
// AXI4 protocol checks
////////////////////

`timescale 1ns/1ps

module tb_mem_port_asserts (
	input logic                 M_AXI4_ACLK,
	input logic                 M_AXI4_ARESETn,
	input axi4_pkg::axi_id_t    M_AXI4_AWID,
	input axi4_pkg::axi_addr_t  M_AXI4_AWADDR,
	input logic                 M_AXI4_AWVALID,
	input logic                 M_AXI4_AWREADY,
	input axi4_pkg::axi_data_t  M_AXI4_WDATA,
	input axi4_pkg::axi_strb_t  M_AXI4_WSTRB,
	input logic                 M_AXI4_WVALID,
	input logic                 M_AXI4_WREADY,
	input logic                 M_AXI4_BREADY,
	input axi4_pkg::axi_id_t    M_AXI4_ARID,
	input axi4_pkg::axi_addr_t  M_AXI4_ARADDR,
	input logic                 M_AXI4_ARVALID,
	input logic                 M_AXI4_ARREADY,
	input logic                 M_AXI4_RREADY,
	input logic                 wr_req_push,
	input logic                 wr_req_full,
	input logic                 rd_req_push,
	input logic                 rd_req_full,
	input logic                 wr_rsp_empty,
	input logic                 rd_rsp_empty,
	input logic                 biu_wr_push,
	input logic                 wr_rsp_ready,
	input biu_pkg::biu_wr_rsp_t biu_wr_rsp,
	input logic                 biu_rd_push,
	input logic                 rd_rsp_ready,
	input biu_pkg::biu_rd_rsp_t biu_rd_rsp
);
	import axi4_pkg::*;
	import biu_pkg::*;

	// VALID held until ready, payload frozen
	a_aw_hold: assert property (@(posedge M_AXI4_ACLK) disable iff (!M_AXI4_ARESETn)
		M_AXI4_AWVALID && !M_AXI4_AWREADY |=> M_AXI4_AWVALID && $stable(M_AXI4_AWADDR)
			&& $stable(M_AXI4_AWID))
		else $error("AWVALID dropped or AW payload changed before AWREADY");
	a_w_hold: assert property (@(posedge M_AXI4_ACLK) disable iff (!M_AXI4_ARESETn)
		M_AXI4_WVALID && !M_AXI4_WREADY |=> M_AXI4_WVALID && $stable(M_AXI4_WDATA)
			&& $stable(M_AXI4_WSTRB))
		else $error("WVALID dropped or W payload changed before WREADY");
	a_ar_hold: assert property (@(posedge M_AXI4_ACLK) disable iff (!M_AXI4_ARESETn)
		M_AXI4_ARVALID && !M_AXI4_ARREADY |=> M_AXI4_ARVALID && $stable(M_AXI4_ARADDR)
			&& $stable(M_AXI4_ARID))
		else $error("ARVALID dropped or AR payload changed before ARREADY");

	// id is a zero-extended client id
	a_awid_fit: assert property (@(posedge M_AXI4_ACLK) disable iff (!M_AXI4_ARESETn)
		M_AXI4_AWVALID |-> M_AXI4_AWID[AXI_ID_W-1:CID_W] == '0)
		else $error("AWID wider than a client id");
	a_arid_fit: assert property (@(posedge M_AXI4_ACLK) disable iff (!M_AXI4_ARESETn)
		M_AXI4_ARVALID |-> M_AXI4_ARID[AXI_ID_W-1:CID_W] == '0)
		else $error("ARID wider than a client id");

	a_wr_req_full: assert property (@(posedge M_AXI4_ACLK) disable iff (!M_AXI4_ARESETn)
		!(wr_req_push && wr_req_full))
		else $error("push into full write request queue");
	a_rd_req_full: assert property (@(posedge M_AXI4_ACLK) disable iff (!M_AXI4_ARESETn)
		!(rd_req_push && rd_req_full))
		else $error("push into full read request queue");
	// bus unit holds its entry while the response queue is full
	a_wr_rsp_hold: assert property (@(posedge M_AXI4_ACLK) disable iff (!M_AXI4_ARESETn)
		biu_wr_push && !wr_rsp_ready |=> biu_wr_push && $stable(biu_wr_rsp))
		else $error("write response dropped while queue full");
	a_rd_rsp_hold: assert property (@(posedge M_AXI4_ACLK) disable iff (!M_AXI4_ARESETn)
		biu_rd_push && !rd_rsp_ready |=> biu_rd_push && $stable(biu_rd_rsp))
		else $error("read response dropped while queue full");

	a_reset_state: assert property (@(posedge M_AXI4_ACLK) $rose(M_AXI4_ARESETn)
		|-> !M_AXI4_AWVALID && !M_AXI4_WVALID && !M_AXI4_ARVALID && M_AXI4_BREADY
		&& M_AXI4_RREADY && wr_rsp_empty && rd_rsp_empty && !wr_req_full && !rd_req_full)
		else $error("control outputs not idle after reset");

endmodule

bind mem_port_top tb_mem_port_asserts mem_port_asserts_i (
	.M_AXI4_ACLK(M_AXI4_ACLK), .M_AXI4_ARESETn(M_AXI4_ARESETn),
	.M_AXI4_AWID(M_AXI4_AWID), .M_AXI4_AWADDR(M_AXI4_AWADDR),
	.M_AXI4_AWVALID(M_AXI4_AWVALID), .M_AXI4_AWREADY(M_AXI4_AWREADY),
	.M_AXI4_WDATA(M_AXI4_WDATA), .M_AXI4_WSTRB(M_AXI4_WSTRB),
	.M_AXI4_WVALID(M_AXI4_WVALID), .M_AXI4_WREADY(M_AXI4_WREADY),
	.M_AXI4_BREADY(M_AXI4_BREADY), .M_AXI4_ARID(M_AXI4_ARID),
	.M_AXI4_ARADDR(M_AXI4_ARADDR), .M_AXI4_ARVALID(M_AXI4_ARVALID),
	.M_AXI4_ARREADY(M_AXI4_ARREADY), .M_AXI4_RREADY(M_AXI4_RREADY),
	.wr_req_push(wr_req_push), .wr_req_full(wr_req_full),
	.rd_req_push(rd_req_push), .rd_req_full(rd_req_full),
	.wr_rsp_empty(wr_rsp_empty), .rd_rsp_empty(rd_rsp_empty),
	.biu_wr_push(biu_wr_push), .wr_rsp_ready(wr_rsp_ready), .biu_wr_rsp(biu_wr_rsp),
	.biu_rd_push(biu_rd_push), .rd_rsp_ready(rd_rsp_ready), .biu_rd_rsp(biu_rd_rsp)
);

// ==== tb_mem_port.sv ====
////////////////////
// memory port testbench
////////////////////

`timescale 1ns/1ps

module tb_mem_port;
	import axi4_pkg::*;
	import biu_pkg::*;

	localparam int        N_REQ          = 2 + 8 + 24 + 24 + 4;	// requests over all tests
	localparam int        TIMEOUT_CYCLES = 40 * N_REQ;
	localparam axi_addr_t MEM_BYTES      = 32'd256;	// 64-word window
	localparam logic [31:0] LFSR_TAPS    = 32'h80200003;

	logic M_AXI4_ACLK, M_AXI4_ARESETn;
	axi_id_t M_AXI4_AWID, M_AXI4_BID, M_AXI4_ARID, M_AXI4_RID;
	axi_addr_t M_AXI4_AWADDR, M_AXI4_ARADDR;
	axi_data_t M_AXI4_WDATA, M_AXI4_RDATA;
	axi_strb_t M_AXI4_WSTRB;
	axi_resp_t M_AXI4_BRESP, M_AXI4_RRESP;
	logic M_AXI4_AWVALID, M_AXI4_AWREADY, M_AXI4_WVALID, M_AXI4_WREADY;
	logic M_AXI4_BVALID, M_AXI4_BREADY, M_AXI4_ARVALID, M_AXI4_ARREADY;
	logic M_AXI4_RLAST, M_AXI4_RVALID, M_AXI4_RREADY;
	logic wr_req_push, wr_req_full, rd_req_push, rd_req_full;
	logic wr_rsp_pop, wr_rsp_empty, rd_rsp_pop, rd_rsp_empty;
	biu_wr_req_t wr_req;
	biu_rd_req_t rd_req;
	biu_wr_rsp_t wr_rsp;
	biu_rd_rsp_t rd_rsp;

	axi_data_t   slv_mem [64];	// slave model storage
	axi_data_t   ref_mem [64];	// expected contents
	biu_wr_rsp_t exp_wr [$];	// scoreboard per channel
	biu_rd_rsp_t exp_rd [$];
	axi_id_t     aw_id_q [$], b_id_q [$], r_id_q [$];
	axi_addr_t   aw_addr_q [$];
	axi_data_t   w_data_q [$], r_data_q [$];
	axi_strb_t   w_strb_q [$];
	axi_resp_t   b_resp_q [$], r_resp_q [$];
	axi_addr_t   slv_addr;
	logic [31:0] lfsr = 32'hf4f71039;
	int          errors, checks, cycles;
	string       test_name = "reset";
	logic        pop_en, saw_b_block, saw_r_block;

	mem_port_top mem_port_top_i (.*);

	initial
	begin
		M_AXI4_ACLK = 1'b0;
		forever #5 M_AXI4_ACLK = ~M_AXI4_ACLK;
	end

	function automatic logic rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = {1'b0, lfsr[31:1]} ^ (b ? LFSR_TAPS : 32'h0);	// galois step
		return b;
	endfunction

	function automatic logic in_window(axi_addr_t a);
		return a < MEM_BYTES;
	endfunction

	function automatic axi_data_t fill_word(int i);
		return 32'hc0de_0000 | axi_data_t'(i * 257);	// unique per word index
	endfunction

	function automatic axi_data_t merge_bytes(axi_data_t old_w, axi_data_t new_w, axi_strb_t s);
		axi_data_t r;
		r = old_w;
		for (int b = 0; b < AXI_STRB_W; b++)
			if (s[b])
				r[8*b +: 8] = new_w[8*b +: 8];
		return r;
	endfunction

	task automatic check(string what, logic [63:0] exp, logic [63:0] act);
		checks++;
		assert (exp === act)
		else
		begin
			errors++;
			$display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	// one client write, expected response and memory computed here
	task automatic push_write(cid_t cid, axi_addr_t addr, axi_data_t data, axi_strb_t strb);
		biu_wr_rsp_t e;
		@(posedge M_AXI4_ACLK);
		while (wr_req_full)
			@(posedge M_AXI4_ACLK);
		wr_req      <= '{cid: cid, addr: addr, data: data, strb: strb};
		wr_req_push <= 1'b1;
		@(posedge M_AXI4_ACLK);
		wr_req_push <= 1'b0;
		e.cid  = cid;
		e.resp = in_window(addr) ? RESP_OKAY : RESP_DECERR;
		exp_wr.push_back(e);
		if (in_window(addr))
			ref_mem[addr[7:2]] = merge_bytes(ref_mem[addr[7:2]], data, strb);
	endtask

	task automatic push_read(cid_t cid, axi_addr_t addr);
		biu_rd_rsp_t e;
		@(posedge M_AXI4_ACLK);
		while (rd_req_full)
			@(posedge M_AXI4_ACLK);
		rd_req      <= '{cid: cid, addr: addr};
		rd_req_push <= 1'b1;
		@(posedge M_AXI4_ACLK);
		rd_req_push <= 1'b0;
		e.cid  = cid;
		e.data = in_window(addr) ? ref_mem[addr[7:2]] : '0;	// decode error reads zero
		e.resp = in_window(addr) ? RESP_OKAY : RESP_DECERR;
		exp_rd.push_back(e);
	endtask

	// wait until every issued request has been answered
	task automatic drain();
		while (exp_wr.size() > 0 || exp_rd.size() > 0)
			@(posedge M_AXI4_ACLK);
	endtask

	// client response side, pop/empty sampled on the edge
	always @(posedge M_AXI4_ACLK)
	begin
		if (M_AXI4_ARESETn && wr_rsp_pop && !wr_rsp_empty)
		begin
			if (exp_wr.size() == 0)
			begin
				errors++;
				$display("%s: write response with no request outstanding", test_name);
			end
			else
				check("write response", 64'(exp_wr.pop_front()), 64'(wr_rsp));
		end
		if (M_AXI4_ARESETn && rd_rsp_pop && !rd_rsp_empty)
		begin
			if (exp_rd.size() == 0)
			begin
				errors++;
				$display("%s: read response with no request outstanding", test_name);
			end
			else
				check("read response", 64'(exp_rd.pop_front()), 64'(rd_rsp));
		end
		wr_rsp_pop <= pop_en;
		rd_rsp_pop <= pop_en;
	end

	// AXI4 slave model with random stalls
	always @(posedge M_AXI4_ACLK)
	begin
		if (!M_AXI4_ARESETn)
		begin
			M_AXI4_AWREADY <= 1'b0;
			M_AXI4_WREADY  <= 1'b0;
			M_AXI4_ARREADY <= 1'b0;
			M_AXI4_BVALID  <= 1'b0;
			M_AXI4_RVALID  <= 1'b0;
		end
		else
		begin
			if (M_AXI4_AWVALID && M_AXI4_AWREADY)
			begin
				aw_id_q.push_back(M_AXI4_AWID);
				aw_addr_q.push_back(M_AXI4_AWADDR);
			end
			if (M_AXI4_WVALID && M_AXI4_WREADY)
			begin
				w_data_q.push_back(M_AXI4_WDATA);
				w_strb_q.push_back(M_AXI4_WSTRB);
			end
			if (aw_addr_q.size() > 0 && w_data_q.size() > 0)	// address and data paired
			begin
				slv_addr = aw_addr_q.pop_front();
				if (in_window(slv_addr))
					slv_mem[slv_addr[7:2]] = merge_bytes(slv_mem[slv_addr[7:2]],
						w_data_q.pop_front(), w_strb_q.pop_front());
				else
				begin
					void'(w_data_q.pop_front());
					void'(w_strb_q.pop_front());
				end
				b_id_q.push_back(aw_id_q.pop_front());
				b_resp_q.push_back(in_window(slv_addr) ? RESP_OKAY : RESP_DECERR);
			end
			if (M_AXI4_ARVALID && M_AXI4_ARREADY)
			begin
				r_id_q.push_back(M_AXI4_ARID);
				r_data_q.push_back(in_window(M_AXI4_ARADDR) ? slv_mem[M_AXI4_ARADDR[7:2]] : '0);
				r_resp_q.push_back(in_window(M_AXI4_ARADDR) ? RESP_OKAY : RESP_DECERR);
			end
			if (M_AXI4_BVALID && M_AXI4_BREADY)
				M_AXI4_BVALID <= 1'b0;
			else if (!M_AXI4_BVALID && b_id_q.size() > 0 && rand_bit())
			begin
				M_AXI4_BVALID <= 1'b1;
				M_AXI4_BID    <= b_id_q.pop_front();
				M_AXI4_BRESP  <= b_resp_q.pop_front();
			end
			if (M_AXI4_RVALID && M_AXI4_RREADY)
				M_AXI4_RVALID <= 1'b0;
			else if (!M_AXI4_RVALID && r_id_q.size() > 0 && rand_bit())
			begin
				M_AXI4_RVALID <= 1'b1;
				M_AXI4_RLAST  <= 1'b1;	// always single beat
				M_AXI4_RID    <= r_id_q.pop_front();
				M_AXI4_RDATA  <= r_data_q.pop_front();
				M_AXI4_RRESP  <= r_resp_q.pop_front();
			end
			M_AXI4_AWREADY <= rand_bit();
			M_AXI4_WREADY  <= rand_bit();
			M_AXI4_ARREADY <= rand_bit();
		end
	end

	// run limit
	always @(posedge M_AXI4_ACLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout in %s after %0d cycles, responses still missing", test_name, cycles);
			$display("checks %0d, errors %0d", checks, errors);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial
	begin
		M_AXI4_ARESETn = 1'b0;
		wr_req_push <= 1'b0;
		rd_req_push <= 1'b0;
		wr_req      <= '0;
		rd_req      <= '0;
		wr_rsp_pop  <= 1'b0;
		rd_rsp_pop  <= 1'b0;
		pop_en      <= 1'b0;
		M_AXI4_AWREADY <= 1'b0;
		M_AXI4_WREADY  <= 1'b0;
		M_AXI4_ARREADY <= 1'b0;
		M_AXI4_BVALID  <= 1'b0;
		M_AXI4_RVALID  <= 1'b0;
		M_AXI4_BID <= '0;
		M_AXI4_BRESP <= '0;
		M_AXI4_RID <= '0;
		M_AXI4_RDATA <= '0;
		M_AXI4_RRESP <= '0;
		M_AXI4_RLAST <= 1'b0;
		for (int i = 0; i < 64; i++)
		begin
			slv_mem[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		repeat (4) @(posedge M_AXI4_ACLK);
		M_AXI4_ARESETn <= 1'b1;
		@(posedge M_AXI4_ACLK);
		check("AWVALID", 64'(0), 64'(M_AXI4_AWVALID));
		check("WVALID", 64'(0), 64'(M_AXI4_WVALID));
		check("ARVALID", 64'(0), 64'(M_AXI4_ARVALID));
		check("BREADY", 64'(1), 64'(M_AXI4_BREADY));
		check("RREADY", 64'(1), 64'(M_AXI4_RREADY));
		check("write rsp empty", 64'(1), 64'(wr_rsp_empty));
		check("read rsp empty", 64'(1), 64'(rd_rsp_empty));
		pop_en <= 1'b1;

		test_name = "write then read";	// bytes 0 and 2 replaced
		push_write(cid_t'(1), 32'h10, 32'hdeadbeef, 4'b0101);
		drain();
		push_read(cid_t'(2), 32'h10);
		drain();

		test_name = "client ids";
		for (int i = 0; i < 4; i++)
		begin
			push_write(cid_t'(i + 3), axi_addr_t'(32'h40 + 4 * i), axi_data_t'(32'h5000 + i), 4'hf);
			push_read(cid_t'(i + 8), axi_addr_t'(32'h80 + 4 * i));
		end
		drain();

		test_name = "bus stalls";
		for (int i = 0; i < 12; i++)
			push_write(cid_t'(i), axi_addr_t'(((i * 7) % 64) * 4),
				axi_data_t'(32'h12340000 ^ (i * 32'h9e3779b9)), axi_strb_t'(i + 1));
		drain();
		for (int i = 0; i < 12; i++)
			push_read(cid_t'(i), axi_addr_t'(((i * 7) % 64) * 4));
		drain();

		test_name = "back-pressure";	// more responses than the unit can hold
		pop_en      <= 1'b0;
		saw_b_block = 1'b0;
		saw_r_block = 1'b0;
		for (int i = 0; i < 3 * QUEUE_DEPTH; i++)
		begin
			push_write(cid_t'(i), axi_addr_t'((48 + i) * 4), axi_data_t'(32'ha0a0_0000 + i), 4'hf);
			push_read(cid_t'(15 - i), axi_addr_t'(i * 4));
		end
		for (int n = 0; n < 300 && !(saw_b_block && saw_r_block); n++)
		begin
			@(posedge M_AXI4_ACLK);
			if (!M_AXI4_BREADY)
				saw_b_block = 1'b1;
			if (!M_AXI4_RREADY)
				saw_r_block = 1'b1;
		end
		check("BREADY blocked", 64'(1), 64'(saw_b_block));
		check("RREADY blocked", 64'(1), 64'(saw_r_block));
		pop_en <= 1'b1;
		drain();

		test_name = "decode error";
		push_write(cid_t'(6), 32'h100, 32'hbad0bad0, 4'hf);
		push_write(cid_t'(7), 32'h8000_0000, 32'h0badf00d, 4'hf);
		push_read(cid_t'(6), 32'h100);
		push_read(cid_t'(7), 32'h8000_0000);
		drain();

		test_name = "memory contents";
		for (int i = 0; i < 64; i++)
			check("word", 64'(ref_mem[i]), 64'(slv_mem[i]));

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
axi4_pkg.sv
biu_pkg.sv
biu_req_fifo.sv
biu_rsp_fifo.sv
axi4_master_biu.sv
mem_port_top.sv
tb_mem_port_asserts.sv
tb_mem_port.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_mem_port -f files.f -o sim_tb
	./obj_dir/sim_tb 2>&1 | tee sim.log
	@if grep -q -e "TESTBENCH FAILED" -e "%Error" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
